//--- ethRxSwitch.sv
`default_nettype none

module ethRxSwitch #(
  parameter int ErrCountWidth = 8
) (
  input  wire                RxClk,
  input  wire                reset,
  input  wire                rxValid,
  input  wire                dataReady,
  input  wire [7:0]          rxData,
  input  wire                inActive,    // Eth1 link
  input  wire [2:0]          outActive,   // Eth2, PS, RT
  input  wire [3:0]          boardId,
  input  wire [15:0]         bcBoardMask,
  input  wire                clearErrors,
  input  wire [4:0]          regAddr,
  output wire                frameDone,
  output switchPkg::outMaskT fwdMask,
  output wire                crcError,
  output wire                ipv4Error,
  output wire                isHub,
  output wire                isBcHub,
  output wire [31:0]         regData
);

  wire                      byteStrobe;
  wire                      headerDone;
  wire                      ipv4Start;
  wire [4:0]                dataIndex;
  wire [15:0]               etherType;
  switchPkg::macAddrT       destMac;
  switchPkg::macAddrT       srcMac;
  switchPkg::boardMaskT     learnedBoards;

  rxFrameParser parser (
    .RxClk(RxClk), .reset(reset), .rxValid(rxValid), .dataReady(dataReady), .rxData(rxData),
    .byteStrobe(byteStrobe), .headerDone(headerDone), .frameDone(frameDone),
    .crcError(crcError), .ipv4Start(ipv4Start), .destMac(destMac), .srcMac(srcMac),
    .etherType(etherType), .dataIndex(dataIndex)
  );

  ipv4Checker ipv4Check (
    .RxClk(RxClk), .reset(reset), .byteStrobe(byteStrobe), .ipv4Start(ipv4Start),
    .dataIndex(dataIndex), .rxData(rxData), .etherType(etherType), .ipv4Error(ipv4Error)
  );

  fpgaLearnTable learnTable (
    .RxClk(RxClk), .reset(reset), .inActive(inActive), .headerDone(headerDone),
    .srcMac(srcMac), .bcBoardMask(bcBoardMask), .learnedBoards(learnedBoards),
    .isHub(isHub), .isBcHub(isBcHub)
  );

  fwdDecision fwd (
    .RxClk(RxClk), .reset(reset), .headerDone(headerDone), .destMac(destMac),
    .learnedBoards(learnedBoards), .boardId(boardId), .outActive(outActive),
    .fwdMask(fwdMask)
  );

  switchStatusRegs #(.ErrCountWidth(ErrCountWidth)) statusRegs (
    .RxClk(RxClk), .reset(reset), .clearErrors(clearErrors), .frameDone(frameDone),
    .crcError(crcError), .ipv4Error(ipv4Error), .fwdMask(fwdMask),
    .learnedBoards(learnedBoards), .inActive(inActive), .outActive(outActive),
    .regAddr(regAddr), .regData(regData)
  );

endmodule

`default_nettype wire

//--- tbFrameTasks.svh
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

logic [31:0] lfsrState = 32'h77cd_d922; // Fixed seed
logic [7:0]  payload [46];              // Data field, IPv4 header in bytes 0 to 19
logic [7:0]  frameBytes [$];            // Wire order, preamble first

// Galois LFSR, one step per bit taken
function automatic logic [7:0] nextBits(input int count);
  logic [7:0] bits;
  int         i;
  bits = 8'd0;
  for (i = 0; i < count; i++) begin
    bits      = {bits[6:0], lfsrState[0]};
    lfsrState = {1'b0, lfsrState[31:1]} ^ (lfsrState[0] ? 32'h8020_0003 : 32'd0);
  end
  return bits;
endfunction

// Reflected CRC-32, LSB of each byte first as on the wire
function automatic logic [31:0] crcByte(input logic [31:0] crc, input logic [7:0] data);
  logic [31:0] c;
  int          i;
  c = crc ^ {24'd0, data};
  for (i = 0; i < 8; i++)
    c = c[0] ? ({1'b0, c[31:1]} ^ 32'hEDB8_8320) : {1'b0, c[31:1]};
  return c;
endfunction

// Ones-complement sum of the ten IPv4 header words
function automatic logic [15:0] onesSum();
  logic [31:0] sum;
  int          i;
  sum = 32'd0;
  for (i = 0; i < 20; i += 2)
    sum = sum + {16'd0, payload[i], payload[i + 1]};
  while (sum[31:16] != 16'd0)
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]}; // End-around carry
  return sum[15:0];
endfunction

task automatic fillPayload(input logic withCksum);
  logic [15:0] cks;
  int          i;
  for (i = 0; i < 46; i++)
    payload[i] = nextBits(8);
  if (withCksum) begin
    payload[10] = 8'h00; // Checksum field is zero while summing
    payload[11] = 8'h00;
    cks = ~onesSum();
    payload[10] = cks[15:8];
    payload[11] = cks[7:0];
  end
endtask

task automatic buildFrame(input logic [47:0] dest, input logic [47:0] src,
                          input logic [15:0] etype, input logic badFcs);
  logic [31:0] crc;
  int          i;
  frameBytes.delete();
  for (i = 0; i < 7; i++)
    frameBytes.push_back(8'h55);             // Preamble
  frameBytes.push_back(switchPkg::SfdByte);
  for (i = 0; i < 6; i++)
    frameBytes.push_back(dest[47 - 8 * i -: 8]);
  for (i = 0; i < 6; i++)
    frameBytes.push_back(src[47 - 8 * i -: 8]);
  frameBytes.push_back(etype[15:8]);
  frameBytes.push_back(etype[7:0]);
  for (i = 0; i < 46; i++)
    frameBytes.push_back(payload[i]);
  crc = 32'hFFFF_FFFF;
  for (i = 8; i < frameBytes.size(); i++)
    crc = crcByte(crc, frameBytes[i]);       // Header and payload only
  crc = ~crc;
  if (badFcs)
    crc = crc ^ 32'h0000_0100;               // One flipped FCS bit
  for (i = 0; i < 4; i++)
    frameBytes.push_back(crc[8 * i +: 8]);   // Low byte first
endtask

`endif

//--- ethRxSwitchTb.sv
`default_nettype none

module ethRxSwitchTb;

  localparam int NumFrames      = 11;
  localparam int FrameBytes     = 72; // Preamble, SFD, header, 46 payload bytes, FCS
  localparam int FrameGap       = 4;  // Setup and drain cycles per frame
  localparam int OtherCycles    = 100;
  localparam int WatchdogCycles = 2 * (NumFrames * (FrameBytes + FrameGap) + OtherCycles);
  localparam logic [3:0] MyBoard = 4'd2;

  logic        RxClk = 1'b0;
  logic        reset;
  logic        rxValid;
  logic        dataReady;
  logic [7:0]  rxData;
  logic        inActive;
  logic [2:0]  outActive;
  logic [3:0]  boardId;
  logic [15:0] bcBoardMask;
  logic        clearErrors;
  logic [4:0]  regAddr;
  wire         frameDone;
  wire  [2:0]  fwdMask;
  wire         crcError;
  wire         ipv4Error;
  wire         isHub;
  wire         isBcHub;
  wire  [31:0] regData;

  logic [2:0] expMask; // Expected results of the frame in flight
  logic       expCrc;
  logic       expIpv4;
  string      testName;
  int         errors = 0;
  int         testsRun = 0;
  int         testsFailed = 0;
  int         testStartErrors;
  int         frameTotal;  // Counter model
  int         crcTotal;
  int         ipv4Total;
  int         fwdTotal [3];

  logic [47:0] hostMac   = 48'h0200_0000_0001;
  logic [47:0] rtMac     = {switchPkg::LcsrCid, switchPkg::FpgaRtMac, 4'd0, MyBoard};
  logic [47:0] board5Mac = {switchPkg::LcsrCid, switchPkg::FpgaPsMac, 8'h05};
  logic [47:0] board9Mac = {switchPkg::LcsrCid, switchPkg::FpgaPsMac, 8'h09};
  logic [47:0] udpMcMac  = {switchPkg::UdpMulticastPrefix, switchPkg::UdpMulticastFpga};

  `include "tbFrameTasks.svh"

  ethRxSwitch #(.ErrCountWidth(8)) dut (
    .RxClk(RxClk), .reset(reset), .rxValid(rxValid), .dataReady(dataReady), .rxData(rxData),
    .inActive(inActive), .outActive(outActive), .boardId(boardId), .bcBoardMask(bcBoardMask),
    .clearErrors(clearErrors), .regAddr(regAddr), .frameDone(frameDone), .fwdMask(fwdMask),
    .crcError(crcError), .ipv4Error(ipv4Error), .isHub(isHub), .isBcHub(isBcHub),
    .regData(regData)
  );

  always #50 RxClk = ~RxClk;

  maskAtFrameEnd: assert property (@(posedge RxClk) disable iff (reset)
    frameDone |-> (fwdMask == expMask))
    else begin
      $display("FAILED %s fwdMask expected %b actual %b", testName, expMask, $sampled(fwdMask));
      errors++;
    end

  crcAtFrameEnd: assert property (@(posedge RxClk) disable iff (reset)
    frameDone |-> (crcError == expCrc))
    else begin
      $display("FAILED %s crcError expected %b actual %b", testName, expCrc, $sampled(crcError));
      errors++;
    end

  ipv4AtFrameEnd: assert property (@(posedge RxClk) disable iff (reset)
    frameDone |-> (ipv4Error == expIpv4))
    else begin
      $display("FAILED %s ipv4Error expected %b actual %b", testName, expIpv4,
               $sampled(ipv4Error));
      errors++;
    end

  // Drives one frame with random stalls, then waits for frameDone
  task automatic sendFrame(input logic [47:0] dest, input logic [47:0] src,
                           input logic [15:0] etype, input logic badFcs,
                           input logic [2:0] mask, input logic crcE, input logic ipv4E);
    int   i;
    logic seen;
    buildFrame(dest, src, etype, badFcs);
    @(negedge RxClk);
    expMask = mask;
    expCrc  = crcE;
    expIpv4 = ipv4E;
    i = 0;
    while (i < frameBytes.size()) begin
      rxValid   = 1'b1;
      rxData    = frameBytes[i];
      dataReady = (nextBits(3) != 8'h07); // About one stall in eight
      if (dataReady)
        i++;
      @(negedge RxClk);
    end
    rxValid   = 1'b0;  // End of frame
    dataReady = 1'b1;
    rxData    = 8'h00;
    seen      = 1'b0;
    for (i = 0; i < 8 && !seen; i++) begin
      @(negedge RxClk);
      seen = frameDone;
    end
    @(negedge RxClk);  // Assertions sampled frameDone
    if (!seen) begin
      $display("%s: frameDone never came after the frame ended", testName);
      errors++;
    end
    frameTotal++;
    if (crcE)
      crcTotal++;
    if (ipv4E)
      ipv4Total++;
    for (i = 0; i < 3; i++)
      if (mask[i])
        fwdTotal[i]++;
  endtask

  task automatic readReg(input logic [4:0] addr, input logic [31:0] expected);
    @(negedge RxClk);
    regAddr = addr;
    @(negedge RxClk); // One cycle of read latency
    assert (regData == expected)
      else begin
        $display("FAILED %s word %0d expected %h actual %h", testName, addr, expected, regData);
        errors++;
      end
  endtask

  task automatic checkFlag(input string what, input logic actual, input logic expected);
    assert (actual == expected)
      else begin
        $display("FAILED %s %s expected %b actual %b", testName, what, expected, actual);
        errors++;
      end
  endtask

  function automatic logic [31:0] counterWord();
    return {frameTotal[15:0], crcTotal[7:0], ipv4Total[7:0]};
  endfunction

  function automatic logic [31:0] fwdWord();
    return {8'd0, fwdTotal[2][7:0], fwdTotal[1][7:0], fwdTotal[0][7:0]}; // RT, PS, Eth2
  endfunction

  task automatic beginTest(input string name);
    testName        = name;
    testStartErrors = errors;
    testsRun++;
  endtask

  task automatic endTest();
    if (errors == testStartErrors)
      $display("ok    %s", testName);
    else begin
      testsFailed++;
      $display("fail  %s, %0d check errors", testName, errors - testStartErrors);
    end
  endtask

  // Watchdog
  initial begin
    repeat (WatchdogCycles) @(posedge RxClk);
    $display("Watchdog expired after %0d cycles, a test is stuck", WatchdogCycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    rxValid     = 1'b0;
    dataReady   = 1'b1;
    rxData      = 8'h00;
    inActive    = 1'b1;
    outActive   = 3'b111;
    boardId     = MyBoard;
    bcBoardMask = 16'h0000;
    clearErrors = 1'b0;
    regAddr     = 5'd0;
    expMask     = 3'b000;
    expCrc      = 1'b0;
    expIpv4     = 1'b0;
    testName    = "reset";
    frameTotal  = 0;
    crcTotal    = 0;
    ipv4Total   = 0;
    fwdTotal    = '{0, 0, 0};
    repeat (5) @(negedge RxClk);
    reset = 1'b0;

    beginTest("rtUnicast"); // RT primary hit only
    fillPayload(1'b0);
    sendFrame(rtMac, hostMac, 16'h88B5, 1'b0, 3'b100, 1'b0, 1'b0);
    readReg(5'd3, counterWord());
    endTest();

    beginTest("badFcs");
    fillPayload(1'b0);
    sendFrame(rtMac, hostMac, 16'h88B5, 1'b1, 3'b100, 1'b1, 1'b0);
    readReg(5'd3, counterWord());
    @(negedge RxClk);
    clearErrors = 1'b1;
    @(negedge RxClk);
    clearErrors = 1'b0;
    crcTotal    = 0;
    ipv4Total   = 0;
    readReg(5'd3, counterWord());
    endTest();

    beginTest("ipv4Checksum");
    fillPayload(1'b1);
    sendFrame(rtMac, hostMac, switchPkg::Ipv4Type, 1'b0, 3'b100, 1'b0, 1'b0);
    payload[11] = payload[11] ^ 8'h01;   // Break the checksum
    sendFrame(rtMac, hostMac, switchPkg::Ipv4Type, 1'b0, 3'b100, 1'b0, 1'b1);
    sendFrame(rtMac, hostMac, 16'h88B5, 1'b0, 3'b100, 1'b0, 1'b0); // Not IPv4, no flag
    readReg(5'd3, counterWord());
    endTest();

    beginTest("learnBoard5");
    checkFlag("isHub while empty", isHub, 1'b1);
    fillPayload(1'b0);
    sendFrame(rtMac, board5Mac, 16'h88B5, 1'b0, 3'b100, 1'b0, 1'b0);
    checkFlag("isHub after learning", isHub, 1'b0);
    readReg(5'd2, 32'h0000_0020);
    bcBoardMask = 16'h0020;
    @(negedge RxClk);
    checkFlag("isBcHub with board 5 in mask", isBcHub, 1'b0);
    bcBoardMask = 16'h0200;
    @(negedge RxClk);
    checkFlag("isBcHub without board 5", isBcHub, 1'b1);
    sendFrame(board5Mac, hostMac, 16'h88B5, 1'b0, 3'b000, 1'b0, 1'b0); // Board behind us
    sendFrame(board9Mac, hostMac, 16'h88B5, 1'b0, 3'b001, 1'b0, 1'b0); // Unknown board
    inActive = 1'b0;  // Link drop
    @(negedge RxClk);
    checkFlag("isHub after link drop", isHub, 1'b1);
    readReg(5'd2, 32'h0000_0000);
    readReg(5'd1, {28'd0, outActive, 1'b0});
    inActive = 1'b1;
    endTest();

    beginTest("broadcastMulticast");
    sendFrame(switchPkg::BroadcastMac, hostMac, 16'h88B5, 1'b0, 3'b111, 1'b0, 1'b0);
    outActive = 3'b101; // PS down
    sendFrame(switchPkg::BroadcastMac, hostMac, 16'h88B5, 1'b0, 3'b101, 1'b0, 1'b0);
    outActive = 3'b111;
    sendFrame(udpMcMac, hostMac, 16'h88B5, 1'b0, 3'b101, 1'b0, 1'b0); // Eth2 and RT
    readReg(5'd4, fwdWord());
    endTest();

    beginTest("idWords");
    readReg(5'd0, 32'h3057_5345); // ASCII 0WSE
    readReg(5'd5, 32'h0000_0120);
    endTest();

    $display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- fpgaLearnTable.sv
`default_nettype none

module fpgaLearnTable (
  input  wire                  RxClk,
  input  wire                  reset,
  input  wire                  inActive,    // Link up on this in-port
  input  wire                  headerDone,
  input  wire [47:0]           srcMac,
  input  wire [15:0]           bcBoardMask, // Boards taking part in broadcast read
  output switchPkg::boardMaskT learnedBoards,
  output logic                 isHub,
  output logic                 isBcHub
);

  logic isLcsrSrc;

  // Any FPGA board MAC, PS or RT alike
  assign isLcsrSrc = (srcMac[47:24] == switchPkg::LcsrCid);

  always_ff @(posedge RxClk) begin
    if (reset || !inActive)
      learnedBoards <= '0;                         // Link drop forgets the boards
    else if (headerDone && isLcsrSrc)
      learnedBoards[srcMac[3:0]] <= 1'b1;
  end

  // No boards behind this port
  assign isHub   = (learnedBoards == '0);
  assign isBcHub = ((learnedBoards & bcBoardMask) == '0);

endmodule

`default_nettype wire

//--- fwdDecision.sv
`default_nettype none

module fwdDecision (
  input  wire                RxClk,
  input  wire                reset,
  input  wire                headerDone,
  input  wire [47:0]         destMac,
  input  wire [15:0]         learnedBoards, // Boards behind this in-port
  input  wire [3:0]          boardId,
  input  wire [2:0]          outActive,
  output switchPkg::outMaskT fwdMask
);

  switchPkg::macAddrT psMac;
  switchPkg::macAddrT rtMac;
  switchPkg::outMaskT primaryHit;
  switchPkg::outMaskT nextMask;

  logic broadcast;
  logic udpMc;
  logic fpgaMc;
  logic lcsr;
  logic boardFwd;
  logic fpgaMatch;
  logic noMatch;

  // Unicast match, or any multicast sharing the upper bytes
  function automatic logic primaryMatch(input switchPkg::macAddrT dest,
                                        input switchPkg::macAddrT prim);
    return (dest[47:41] == prim[47:41]) && (dest[39:8] == prim[39:8]) &&
           ((dest[7:0] == prim[7:0]) || dest[40]);
  endfunction

  assign psMac   = {switchPkg::LcsrCid, switchPkg::FpgaPsMac, 4'd0, boardId};
  assign rtMac   = {switchPkg::LcsrCid, switchPkg::FpgaRtMac, 4'd0, boardId};

  always_comb begin
    primaryHit[0] = primaryMatch(destMac, switchPkg::BroadcastMac); // Host on Eth2 not learned
    primaryHit[1] = primaryMatch(destMac, psMac);
    primaryHit[2] = primaryMatch(destMac, rtMac);

    broadcast = (destMac == switchPkg::BroadcastMac);
    udpMc     = (destMac[47:24] == switchPkg::UdpMulticastPrefix);
    fpgaMc    = ((destMac[47:24] == switchPkg::LcsrCidMulticast) && (destMac[7:0] == 8'hFF)) ||
                (udpMc && (destMac[23:0] == switchPkg::UdpMulticastFpga));
    lcsr      = ((destMac[47:24] & ~switchPkg::MulticastBit) == switchPkg::LcsrCid);
    boardFwd  = !learnedBoards[destMac[3:0]] && (destMac[3:0] != boardId); // Board not behind us
    fpgaMatch = (lcsr && (boardFwd || destMac[40])) || fpgaMc;
    // Known LCSR boards behind this port are not flooded
    noMatch   = (primaryHit == '0) && !fpgaMatch && !lcsr;

    nextMask[0] = broadcast || udpMc || primaryHit[0] || fpgaMatch || noMatch; // Eth2
    nextMask[1] = broadcast || (udpMc && !fpgaMc) || primaryHit[1];           // PS
    nextMask[2] = broadcast || fpgaMc || primaryHit[2];                       // RT
  end

  always_ff @(posedge RxClk) begin
    if (reset)
      fwdMask <= '0;
    else if (headerDone)
      fwdMask <= nextMask & outActive;  // Down ports never selected
  end

  // Mask taken at the header never names a port that was down then
  maskActiveOnly: assert property (@(posedge RxClk) disable iff (reset)
    headerDone |=> ((fwdMask & ~$past(outActive)) == '0))
    else $error("fwdMask selects an inactive out-port");

endmodule

`default_nettype wire

//--- ipv4Checker.sv
`default_nettype none

module ipv4Checker (
  input  wire        RxClk,
  input  wire        reset,
  input  wire        byteStrobe, // Data byte accepted
  input  wire        ipv4Start,  // SFD, clears the flag
  input  wire [4:0]  dataIndex,
  input  wire [7:0]  rxData,
  input  wire [15:0] etherType,
  output logic       ipv4Error
);

  logic [16:0] cksum;   // Running sum, bit 16 is the pending carry
  logic [16:0] lastSum; // Sum with the current low byte added
  logic [16:0] folded;  // End-around carry applied
  logic        isIpv4;

  always_comb begin
    lastSum = cksum + {9'd0, rxData};
    folded  = {1'b0, lastSum[15:0]} + {16'd0, lastSum[16]};
  end

  assign isIpv4 = (etherType == switchPkg::Ipv4Type);

  always_ff @(posedge RxClk) begin
    if (byteStrobe) begin
      if (dataIndex == 5'(switchPkg::Ipv4FirstByte))
        cksum <= {1'b0, rxData, 8'd0};                // First high byte
      else if (dataIndex < 5'(switchPkg::Ipv4LastByte)) begin
        if (dataIndex[0])
          cksum <= lastSum;                           // Low byte of a word
        else
          cksum <= {1'b0, cksum[15:0]} + {1'b0, rxData, 7'd0, cksum[16]}; // High byte plus carry
      end
    end
  end

  always_ff @(posedge RxClk) begin
    if (reset)
      ipv4Error <= 1'b0;
    else if (ipv4Start)
      ipv4Error <= 1'b0;
    else if (byteStrobe && (dataIndex == 5'(switchPkg::Ipv4LastByte)))
      ipv4Error <= isIpv4 && (folded != 17'h0FFFF); // Good header sums to all ones
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
switchPkg.sv
rxFrameParser.sv
ipv4Checker.sv
fpgaLearnTable.sv
fwdDecision.sv
switchStatusRegs.sv
ethRxSwitch.sv
ethRxSwitchTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the Eth1 receive switch testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f project.f --top-module ethRxSwitchTb -o ethRxSwitchSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ethRxSwitchSim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$log"; then
  exit 0
fi
echo "Simulation reported failure, see $log"
exit 1

//--- rxFrameParser.sv
`default_nettype none

module rxFrameParser (
  input  wire                RxClk,
  input  wire                reset,
  input  wire                rxValid,    // Byte present on rxData
  input  wire                dataReady,  // Client qualifier for rxValid
  input  wire [7:0]          rxData,
  output logic               byteStrobe, // Counted byte in the data state
  output logic               headerDone, // Cycle after the last header byte
  output logic               frameDone,  // Cycle after rxValid drops in data
  output logic               crcError,   // Held until the next frame end
  output logic               ipv4Start,  // SFD accepted
  output switchPkg::macAddrT destMac,
  output switchPkg::macAddrT srcMac,
  output logic [15:0]        etherType,
  output logic [4:0]         dataIndex   // Saturates at 31
);

  switchPkg::rxStateT rxState;

  logic         rxStrobe;    // Byte counts only with both qualifiers
  logic [4:0]   byteCount;   // Header offset, then data offset
  logic [31:0]  crcReg;
  logic [7:0]   rxDataRev;   // LSB first into the CRC
  logic [111:0] headerShift; // First header byte ends up at the top

  // Ethernet CRC-32, MSB first form, one byte per call
  function automatic logic [31:0] crcNext(input logic [31:0] crc, input logic [7:0] data);
    logic [31:0] c;
    logic        fb;
    int          i;
    c = crc;
    for (i = 7; i >= 0; i--) begin
      fb = c[31] ^ data[i];
      c  = {c[30:0], 1'b0} ^ (fb ? 32'h04C11DB7 : 32'd0);
    end
    return c;
  endfunction

  always_comb begin
    rxStrobe   = rxValid & dataReady;
    byteStrobe = rxStrobe && (rxState == switchPkg::RxData);
    ipv4Start  = rxStrobe && (rxState == switchPkg::RxIdle) && (rxData == switchPkg::SfdByte);
  end

  assign rxDataRev = {<<{rxData}};
  assign dataIndex = byteCount;

  // Fixed positions once all 14 bytes are in
  assign destMac   = headerShift[111:64];
  assign srcMac    = headerShift[63:16];
  assign etherType = headerShift[15:0];

  always_ff @(posedge RxClk) begin
    headerDone <= 1'b0; // Strobes
    frameDone  <= 1'b0;
    if (reset) begin
      rxState   <= switchPkg::RxIdle;
      byteCount <= 5'd0;
      crcError  <= 1'b0;
    end else begin
      case (rxState)
        switchPkg::RxIdle: begin
          if (ipv4Start) begin
            rxState   <= switchPkg::RxHeader;
            byteCount <= 5'd0;
          end
        end
        switchPkg::RxHeader: begin
          if (rxStrobe) begin
            byteCount <= byteCount + 5'd1;
            if (byteCount == 5'(switchPkg::HeaderBytes - 1)) begin
              rxState    <= switchPkg::RxData;
              byteCount  <= 5'd0;   // Data offsets start at zero
              headerDone <= 1'b1;
            end
          end else if (!rxValid) begin
            rxState <= switchPkg::RxIdle; // Runt, no frameDone
          end
        end
        switchPkg::RxData: begin
          if (rxStrobe) begin
            if (byteCount != 5'd31)
              byteCount <= byteCount + 5'd1;
          end else if (!rxValid) begin
            rxState   <= switchPkg::RxIdle;
            frameDone <= 1'b1;
            crcError  <= (crcReg != switchPkg::CrcResidue); // FCS already folded in
          end
        end
        default: rxState <= switchPkg::RxIdle;
      endcase
    end
  end

  // CRC and header capture
  always_ff @(posedge RxClk) begin
    if (ipv4Start)
      crcReg <= 32'hFFFF_FFFF;                   // Seed after SFD
    else if (rxStrobe && (rxState != switchPkg::RxIdle))
      crcReg <= crcNext(crcReg, rxDataRev);
    if (rxStrobe && (rxState == switchPkg::RxHeader))
      headerShift <= {headerShift[103:0], rxData};
  end

  // One frame end per frame
  frameDoneSingle: assert property (@(posedge RxClk) disable iff (reset)
    frameDone |=> !frameDone)
    else $error("frameDone high on two consecutive cycles");

endmodule

`default_nettype wire

//--- switchPkg.sv
`default_nettype none

package switchPkg;

  // Common widths
  typedef logic [47:0] macAddrT;   // MAC address, first byte on the wire at the top
  typedef logic [15:0] boardMaskT; // One bit per FPGA board id
  typedef logic [2:0]  outMaskT;   // Bit 0 Eth2, bit 1 PS, bit 2 RT

  // Receive FSM states
  typedef enum logic [1:0] {
    RxIdle,   // Preamble, waiting for SFD
    RxHeader, // 14 header bytes
    RxData    // Payload and FCS
  } rxStateT;

  // Vendor id used by the FPGA boards
  localparam logic [23:0] LcsrCid            = 24'hFA610E;
  localparam logic [23:0] MulticastBit       = 24'h010000;
  localparam logic [23:0] LcsrCidMulticast   = LcsrCid | MulticastBit;

  // IPv4 multicast maps onto 01:00:5E
  localparam logic [23:0] UdpMulticastPrefix = 24'h01005E;
  localparam logic [23:0] UdpMulticastFpga   = 24'h000120; // RT multicast group

  // Middle 16 bits of the board MAC addresses
  localparam logic [15:0] FpgaPsMac          = 16'h0300;
  localparam logic [15:0] FpgaRtMac          = 16'h0E13;

  localparam macAddrT     BroadcastMac       = 48'hFFFF_FFFF_FFFF;

  // Register left after running the FCS through the CRC
  localparam logic [31:0] CrcResidue         = 32'hC704DD7B;
  localparam logic [7:0]  SfdByte            = 8'hD5;

  // Frame layout
  localparam int          HeaderBytes        = 14;
  localparam int          Ipv4FirstByte      = 0;  // Data offsets after the header
  localparam int          Ipv4LastByte       = 19;
  localparam logic [15:0] Ipv4Type           = 16'h0800;

  // "ESW0" as read back byte by byte
  localparam logic [31:0] SwitchIdWord       = "0WSE";

endpackage

`default_nettype wire

//--- switchStatusRegs.sv
`default_nettype none

module switchStatusRegs #(
  parameter int ErrCountWidth = 8  // Error and forward counters
) (
  input  wire        RxClk,
  input  wire        reset,
  input  wire        clearErrors,  // Zeroes both error counters
  input  wire        frameDone,
  input  wire        crcError,
  input  wire        ipv4Error,
  input  wire [2:0]  fwdMask,
  input  wire [15:0] learnedBoards,
  input  wire        inActive,
  input  wire [2:0]  outActive,
  input  wire [4:0]  regAddr,
  output logic [31:0] regData      // One cycle after regAddr
);

  logic [15:0]              frameCount;
  logic [ErrCountWidth-1:0] crcErrCount;
  logic [ErrCountWidth-1:0] ipv4ErrCount;
  logic [ErrCountWidth-1:0] fwdCount [3]; // Index as fwdMask bits
  logic [31:0]              readWord;

  always_ff @(posedge RxClk) begin
    if (reset) begin
      frameCount   <= 16'd0;
      crcErrCount  <= '0;
      ipv4ErrCount <= '0;
      for (int i = 0; i < 3; i++)
        fwdCount[i] <= '0;
    end else begin
      if (frameDone)
        frameCount <= frameCount + 16'd1;  // Wraps

      if (clearErrors) begin
        crcErrCount  <= '0;
        ipv4ErrCount <= '0;
      end else if (frameDone) begin
        if (crcError)
          crcErrCount <= crcErrCount + ErrCountWidth'(1);
        if (ipv4Error)
          ipv4ErrCount <= ipv4ErrCount + ErrCountWidth'(1);
      end

      // Mask is latched at the header, still valid at frame end
      if (frameDone) begin
        for (int i = 0; i < 3; i++)
          if (fwdMask[i])
            fwdCount[i] <= fwdCount[i] + ErrCountWidth'(1);
      end
    end
  end

  always_comb begin
    case (regAddr)
      5'd0:    readWord = switchPkg::SwitchIdWord;
      5'd1:    readWord = {28'd0, outActive, inActive};            // Port status
      5'd2:    readWord = {16'd0, learnedBoards};
      5'd3:    readWord = 32'({frameCount, crcErrCount, ipv4ErrCount});
      5'd4:    readWord = 32'({fwdCount[2], fwdCount[1], fwdCount[0]}); // RT, PS, Eth2
      5'd5:    readWord = {8'd0, switchPkg::UdpMulticastFpga};
      default: readWord = 32'd0;
    endcase
  end

  // Registered read port
  always_ff @(posedge RxClk) begin
    regData <= readWord;
  end

endmodule

`default_nettype wire
